//--- decode_main.f
+incdir+logic
logic/decode_pkg.sv
logic/decode_fields.sv
logic/bank_translate.sv
logic/decode_stage_reg.sv
logic/decode_main.sv
tb/tb_decode_main.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_decode_main
FILELIST  := decode_main.f
PASS_MSG  := Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- tb/tb_decode_main.sv
/* Decode stage testbench.
   Directed tests against a model of field decode, banking and the stage register. */

`timescale 1ns/1ps

`include "decode_macros.svh"

module tb_decode_main;

        import decode_pkg::*;

        localparam int CLK_PERIOD = 100;
        localparam int NUM_TESTS  = 6;

        // Modes visited by the bank test.
        localparam mode_t BANK_MODES [6] = '{`DEC_MODE_FIQ, `DEC_MODE_IRQ, `DEC_MODE_SVC,
                                             `DEC_MODE_ABT, `DEC_MODE_UND, `DEC_MODE_SYS};

        logic           clk = 1'b0;
        logic           reset;
        logic [31:0]    instruction;
        logic           instruction_valid;
        mode_t          cpsr_mode;
        logic           cpsr_i;
        logic           cpsr_f;
        logic           irq;
        logic           fiq;
        logic           abt;
        logic           clear_wb;
        logic           data_stall;
        logic           clear_alu;
        logic           stall_issue;
        uop_t           uop;
        logic           irq_out;
        logic           fiq_out;
        logic           abt_out;
        logic           und_out;
        logic           swi_out;
        integer         seed;

        always #(CLK_PERIOD / 2) clk = ~clk;

        decode_main dut_i (
                .i_clk                  (clk),
                .i_reset                (reset),
                .i_instruction          (instruction),
                .i_instruction_valid    (instruction_valid),
                .i_cpsr_mode            (cpsr_mode),
                .i_cpsr_i               (cpsr_i),
                .i_cpsr_f               (cpsr_f),
                .i_irq                  (irq),
                .i_fiq                  (fiq),
                .i_abt                  (abt),
                .i_clear_from_writeback (clear_wb),
                .i_data_stall           (data_stall),
                .i_clear_from_alu       (clear_alu),
                .i_stall_from_issue     (stall_issue),
                .o_uop                  (uop),
                .o_irq                  (irq_out),
                .o_fiq                  (fiq_out),
                .o_abt                  (abt_out),
                .o_und                  (und_out),
                .o_swi                  (swi_out)
        );

        // --------------------------------------------------------------------
        // Reference model.
        // --------------------------------------------------------------------

        // Banked lookup. First banked register and bank base per mode.
        function automatic phy_idx_t bank_index(input logic [3:0] n, input mode_t m);
                phy_idx_t       base;
                logic [3:0]     first;
                base  = '0;
                first = 4'd15;
                case (m)
                `DEC_MODE_FIQ: begin base = `DEC_PHY_FIQ_BASE; first = 4'd8;  end
                `DEC_MODE_IRQ: begin base = `DEC_PHY_IRQ_BASE; first = 4'd13; end
                `DEC_MODE_SVC: begin base = `DEC_PHY_SVC_BASE; first = 4'd13; end
                `DEC_MODE_ABT: begin base = `DEC_PHY_ABT_BASE; first = 4'd13; end
                `DEC_MODE_UND: begin base = `DEC_PHY_UND_BASE; first = 4'd13; end
                default: first = 4'd15;
                endcase
                if (n >= first && n != 4'd15)
                        return base + phy_idx_t'(n - first);
                return phy_idx_t'(n);
        endfunction

        // Expected micro-op for one word, valid bit and mode.
        function automatic uop_t model_uop(input logic [31:0] w, input logic v, input mode_t m);
                uop_t   u;
                u      = '0;
                u.cond = v ? w[31:28] : `DEC_COND_NV;
                if (w[27:26] == 2'b00)
                begin
                        u.alu_op              = alu_op_t'(w[24:21]);
                        u.flag_update         = w[20];
                        u.dest                = bank_index(w[15:12], m);
                        u.alu_src.regs.idx    = bank_index(w[19:16], m);
                        if (w[25])
                        begin
                                u.shift_src.imm.is_imm = 1'b1;
                                u.shift_src.imm.value  = {24'h0, w[7:0]};
                                u.shift_op             = SH_ROR;
                                u.shift_len.imm.is_imm = 1'b1;
                                u.shift_len.imm.value  = 32'(w[11:8]) * 32'd2;
                        end
                        else
                        begin
                                u.shift_src.regs.idx = bank_index(w[3:0], m);
                                u.shift_op           = shift_op_t'(w[6:5]);
                                if (!w[4])
                                begin
                                        u.shift_len.imm.is_imm = 1'b1;
                                        u.shift_len.imm.value  = 32'(w[11:7]);
                                end
                                else if (!w[7])
                                        u.shift_len.regs.idx = bank_index(w[11:8], m);
                        end
                end
                return u;
        endfunction

        // --------------------------------------------------------------------
        // Checks and drive helpers.
        // --------------------------------------------------------------------

        task automatic check_field(input string name, input logic [127:0] act,
                                   input logic [127:0] exp);
                assert (act === exp)
                else
                begin
                        $display("[FAIL] %s expected 0x%0h got 0x%0h", name, exp, act);
                        $display("Regression failed");
                        $fatal(1, "Stopped on first mismatch.");
                end
        endtask

        task automatic check_uop(input uop_t exp);
                check_field("o_uop.cond", 128'(uop.cond), 128'(exp.cond));
                check_field("o_uop.alu_op", 128'(uop.alu_op), 128'(exp.alu_op));
                check_field("o_uop.flag_update", 128'(uop.flag_update), 128'(exp.flag_update));
                check_field("o_uop.dest", 128'(uop.dest), 128'(exp.dest));
                check_field("o_uop.alu_src", 128'(uop.alu_src), 128'(exp.alu_src));
                check_field("o_uop.shift_src", 128'(uop.shift_src), 128'(exp.shift_src));
                check_field("o_uop.shift_len", 128'(uop.shift_len), 128'(exp.shift_len));
                check_field("o_uop.shift_op", 128'(uop.shift_op), 128'(exp.shift_op));
        endtask

        // Expected flags in the order irq, fiq, abt, und, swi.
        task automatic check_flags(input logic [4:0] exp);
                check_field("o_irq", 128'(irq_out), 128'(exp[4]));
                check_field("o_fiq", 128'(fiq_out), 128'(exp[3]));
                check_field("o_abt", 128'(abt_out), 128'(exp[2]));
                check_field("o_und", 128'(und_out), 128'(exp[1]));
                check_field("o_swi", 128'(swi_out), 128'(exp[0]));
        endtask

        // Controls in the order writeback clear, data stall, ALU clear, issue stall.
        task automatic drive(input logic [31:0] w, input logic v, input logic [3:0] ctrl);
                @(posedge clk);
                instruction       <= w;
                instruction_valid <= v;
                clear_wb          <= ctrl[3];
                data_stall        <= ctrl[2];
                clear_alu         <= ctrl[1];
                stall_issue       <= ctrl[0];
        endtask

        // One capturing edge, then read away from the edge.
        task automatic sample();
                @(posedge clk);
                @(negedge clk);
        endtask

        // --------------------------------------------------------------------
        // Tests.
        // --------------------------------------------------------------------

        task automatic test_reset_state();
                uop_t   exp;
                exp      = '0;
                exp.cond = `DEC_COND_NV;
                check_uop(exp);
                check_flags(5'b00000);
        endtask

        // Immediate, shift by immediate and shift by register in turn.
        task automatic test_dp_usr();
                logic [31:0]    r;
                logic [31:0]    w;
                for (int i = 0; i < 24; i++)
                begin
                        r = $random(seed);
                        case (i % 3)
                        0:       w = {r[31:28], 3'b001, r[24:0]};
                        1:       w = {r[31:28], 3'b000, r[24:12], r[11:5], 1'b0, r[3:0]};
                        default: w = {r[31:28], 3'b000, r[24:8], 1'b0, r[6:5], 1'b1, r[3:0]};
                        endcase
                        drive(w, 1'b1, 4'b0000);
                        sample();
                        check_uop(model_uop(w, 1'b1, `DEC_MODE_USR));
                        check_flags(5'b00000);
                end
        endtask

        task automatic test_banks();
                logic [31:0]    w_reg;
                logic [31:0]    w_imm;
                // ADD r8, r13, r15, LSL r14.
                w_reg = {4'hE, 3'b000, 4'h4, 1'b0, 4'd13, 4'd8, 4'd14, 4'b0001, 4'd15};
                // SUBS r14, r13, #0xCD ror 14.
                // Constant and rotate look like r13 and r14 in their low bits.
                w_imm = {4'hE, 3'b001, 4'h2, 1'b1, 4'd13, 4'd14, 4'h7, 8'hCD};
                foreach (BANK_MODES[k])
                begin
                        drive(w_reg, 1'b1, 4'b0000);
                        cpsr_mode <= BANK_MODES[k];
                        sample();
                        check_uop(model_uop(w_reg, 1'b1, BANK_MODES[k]));
                        check_field("o_uop.shift_src", 128'(uop.shift_src), 128'(33'd15));
                        drive(w_imm, 1'b1, 4'b0000);
                        sample();
                        check_uop(model_uop(w_imm, 1'b1, BANK_MODES[k]));
                        check_field("o_uop.shift_src", 128'(uop.shift_src),
                                    128'({1'b1, 32'hCD}));
                end
                cpsr_mode <= `DEC_MODE_USR;
        endtask

        task automatic test_classes();
                // SWI.
                drive(32'hEF000011, 1'b1, 4'b0000);
                sample();
                check_flags(5'b00001);
                // LDR r0, [r1].
                drive(32'hE5910000, 1'b1, 4'b0000);
                sample();
                check_flags(5'b00010);
                // MUL space, bits 7 and 4 set.
                drive(32'hE0000291, 1'b1, 4'b0000);
                sample();
                check_flags(5'b00010);
                // Bubble, even for an SWI word.
                drive(32'hEF000011, 1'b0, 4'b0000);
                sample();
                check_field("o_uop.cond", 128'(uop.cond), 128'(`DEC_COND_NV));
                check_flags(5'b00000);
        endtask

        task automatic test_priority();
                logic [31:0]    w_a;
                logic [31:0]    w_b;
                uop_t           exp_a;
                uop_t           exp_clr;
                w_a = {4'hE, 3'b001, 4'hD, 1'b1, 4'h0, 4'h3, 4'h2, 8'h5A};
                w_b = {4'h0, 3'b000, 4'h4, 1'b0, 4'h1, 4'h2, 5'd3, 2'b01, 1'b0, 4'h4};
                exp_a = model_uop(w_a, 1'b1, `DEC_MODE_USR);
                exp_clr = exp_a;
                exp_clr.cond = `DEC_COND_NV;
                drive(w_a, 1'b1, 4'b0000);
                irq <= 1'b1;
                sample();
                check_uop(exp_a);
                check_flags(5'b10000);
                // Data stall wins over ALU clear.
                drive(w_b, 1'b1, 4'b0110);
                irq <= 1'b0;
                sample();
                check_uop(exp_a);
                check_flags(5'b10000);
                // Writeback clear wins over data stall.
                drive(w_b, 1'b1, 4'b1100);
                sample();
                check_uop(exp_clr);
                check_flags(5'b00000);
                drive(w_b, 1'b1, 4'b0001);
                sample();
                check_uop(exp_clr);
                check_flags(5'b00000);
                drive(w_b, 1'b1, 4'b0000);
                sample();
                check_uop(model_uop(w_b, 1'b1, `DEC_MODE_USR));
                check_flags(5'b00000);
                // ALU clear on its own turns the held op into a bubble.
                drive(w_a, 1'b1, 4'b0010);
                sample();
                exp_clr = model_uop(w_b, 1'b1, `DEC_MODE_USR);
                exp_clr.cond = `DEC_COND_NV;
                check_uop(exp_clr);
                check_flags(5'b00000);
        endtask

        task automatic test_interrupts();
                logic [4:0]     b;
                logic           v;
                for (int i = 0; i < 32; i++)
                begin
                        b = 5'(i);
                        v = b[3] ^ b[0];
                        drive(32'hE1A00001, v, 4'b0000);
                        irq    <= b[0];
                        cpsr_i <= b[1];
                        fiq    <= b[2];
                        cpsr_f <= b[3];
                        abt    <= b[4];
                        sample();
                        check_flags({b[0] & ~b[1], b[2] & ~b[3], b[4] & v, 2'b00});
                end
        endtask

        // --------------------------------------------------------------------

        initial
        begin
                #(CLK_PERIOD * (NUM_TESTS * 40 + 20));
                $display("Timeout: the tests did not finish in time.");
                $display("Regression failed");
                $fatal(1, "Watchdog expired.");
        end

        initial
        begin
                seed = 29340;
                reset             <= 1'b1;
                instruction       <= '0;
                instruction_valid <= 1'b0;
                cpsr_mode         <= `DEC_MODE_USR;
                cpsr_i            <= 1'b0;
                cpsr_f            <= 1'b0;
                irq               <= 1'b0;
                fiq               <= 1'b0;
                abt               <= 1'b0;
                clear_wb          <= 1'b0;
                data_stall        <= 1'b0;
                clear_alu         <= 1'b0;
                stall_issue       <= 1'b0;
                // Five reset edges, state checked before the first update.
                repeat (4) @(posedge clk);
                @(negedge clk);
                test_reset_state();
                @(posedge clk);
                reset <= 1'b0;
                test_dp_usr();
                test_banks();
                test_classes();
                test_priority();
                test_interrupts();
                $display("Regression passed");
                $finish;
        end

endmodule

//--- logic/decode_main.sv
/* Decode stage top.
   Field decode, bank translation and the stage register in series. */

`timescale 1ns/1ps

module decode_main (
        input   logic                   i_clk,
        input   logic                   i_reset,

        // Instruction from fetch.
        input   logic [31:0]            i_instruction,
        input   logic                   i_instruction_valid,

        // CPSR state.
        input   decode_pkg::mode_t      i_cpsr_mode,
        input   logic                   i_cpsr_i,
        input   logic                   i_cpsr_f,

        // Interrupt events.
        input   logic                   i_irq,
        input   logic                   i_fiq,
        input   logic                   i_abt,

        // Clears and stalls. High to low priority.
        input   logic                   i_clear_from_writeback,
        input   logic                   i_data_stall,
        input   logic                   i_clear_from_alu,
        input   logic                   i_stall_from_issue,

        output  decode_pkg::uop_t       o_uop,
        output  logic                   o_irq,
        output  logic                   o_fiq,
        output  logic                   o_abt,
        output  logic                   o_und,
        output  logic                   o_swi
);

        import decode_pkg::*;

        uop_t   arch_uop;       // Architectural indices.
        uop_t   phy_uop;        // Physical indices.
        logic   swi_nxt;
        logic   und_nxt;

        // ------------------------------------------------------------------

        decode_fields u_decode_fields (
                .i_instruction          (i_instruction),
                .i_instruction_valid    (i_instruction_valid),
                .o_uop                  (arch_uop),
                .o_swi                  (swi_nxt),
                .o_und                  (und_nxt)
        );

        // Banked register lookup for the current mode.
        bank_translate u_bank_translate (
                .i_uop                  (arch_uop),
                .i_cpsr_mode            (i_cpsr_mode),
                .o_uop                  (phy_uop)
        );

        decode_stage_reg u_decode_stage_reg (
                .i_clk                  (i_clk),
                .i_reset                (i_reset),
                .i_clear_from_writeback (i_clear_from_writeback),
                .i_data_stall           (i_data_stall),
                .i_clear_from_alu       (i_clear_from_alu),
                .i_stall_from_issue     (i_stall_from_issue),
                .i_uop                  (phy_uop),
                .i_instruction_valid    (i_instruction_valid),
                .i_swi                  (swi_nxt),
                .i_und                  (und_nxt),
                .i_irq                  (i_irq),
                .i_fiq                  (i_fiq),
                .i_abt                  (i_abt),
                .i_cpsr_i               (i_cpsr_i),
                .i_cpsr_f               (i_cpsr_f),
                .o_uop                  (o_uop),
                .o_irq                  (o_irq),
                .o_fiq                  (o_fiq),
                .o_abt                  (o_abt),
                .o_und                  (o_und),
                .o_swi                  (o_swi)
        );

endmodule

//--- logic/decode_stage_reg.sv
/* Decode pipeline register.
   Prioritized clear/stall handling and interrupt masking. */

`timescale 1ns/1ps

`include "decode_macros.svh"

module decode_stage_reg (
        input   logic                   i_clk,
        input   logic                   i_reset,

        // Clears and stalls. High to low priority.
        input   logic                   i_clear_from_writeback,
        input   logic                   i_data_stall,
        input   logic                   i_clear_from_alu,
        input   logic                   i_stall_from_issue,

        // Next state from decode.
        input   decode_pkg::uop_t       i_uop,
        input   logic                   i_instruction_valid,
        input   logic                   i_swi,
        input   logic                   i_und,

        // Interrupt events and CPSR masks.
        input   logic                   i_irq,
        input   logic                   i_fiq,
        input   logic                   i_abt,
        input   logic                   i_cpsr_i,
        input   logic                   i_cpsr_f,

        output  decode_pkg::uop_t       o_uop,
        output  logic                   o_irq,
        output  logic                   o_fiq,
        output  logic                   o_abt,
        output  logic                   o_und,
        output  logic                   o_swi
);

        logic   irq_nxt;
        logic   fiq_nxt;
        logic   abt_nxt;
        logic   do_clear;
        logic   do_hold;

        // Interrupts pass only while unmasked.
        assign irq_nxt  = i_irq & ~i_cpsr_i;
        assign fiq_nxt  = i_fiq & ~i_cpsr_f;
        // Abort belongs to a real instruction.
        assign abt_nxt  = i_abt & i_instruction_valid;

        // ------------------------------------------------------------------
        // Priority. WB clear, data stall, ALU clear, issue stall, update.
        // ------------------------------------------------------------------

        // ALU clear loses to a data stall.
        assign do_clear = i_clear_from_writeback | (~i_data_stall & i_clear_from_alu);
        assign do_hold  = ~do_clear & (i_data_stall | i_stall_from_issue);

        always_ff @( posedge i_clk )
        begin
                if ( i_reset )
                begin
                        o_uop           <= '0;
                        o_uop.cond      <= `DEC_COND_NV;
                        o_irq           <= 1'b0;
                        o_fiq           <= 1'b0;
                        o_abt           <= 1'b0;
                        o_und           <= 1'b0;
                        o_swi           <= 1'b0;
                end
                else if ( do_clear )
                begin
                        // Bubble. Payload fields keep their values.
                        o_uop.cond      <= `DEC_COND_NV;
                        o_irq           <= 1'b0;
                        o_fiq           <= 1'b0;
                        o_abt           <= 1'b0;
                        o_und           <= 1'b0;
                        o_swi           <= 1'b0;
                end
                else if ( !do_hold )
                begin
                        o_uop           <= i_uop;
                        o_irq           <= irq_nxt;
                        o_fiq           <= fiq_nxt;
                        o_abt           <= abt_nxt;
                        o_und           <= i_und;
                        o_swi           <= i_swi;
                end
        end

endmodule

//--- logic/bank_translate.sv
/* Register bank translator.
   Maps architectural register numbers to physical ones for the CPU mode. */

`timescale 1ns/1ps

`include "decode_macros.svh"

module bank_translate (
        input   decode_pkg::uop_t       i_uop,
        input   decode_pkg::mode_t      i_cpsr_mode,
        output  decode_pkg::uop_t       o_uop
);

        import decode_pkg::*;

        // ------------------------------------------------------------------
        // Index map. Only the low 4 bits carry the architectural number.
        // ------------------------------------------------------------------

        function automatic phy_idx_t map_idx ( input phy_idx_t idx, input mode_t mode );
                arch_idx_t      n;
                phy_idx_t       p;
                begin
                        n = idx[`DEC_ARCH_IDX_W-1:0];
                        // Unbanked by default. r15 never banks.
                        p = phy_idx_t'(n);
                        case ( mode )
                        `DEC_MODE_FIQ:
                                if ( n >= 4'd8 && n <= 4'd14 )
                                        p = `DEC_PHY_FIQ_BASE + phy_idx_t'(n - 4'd8);
                        `DEC_MODE_IRQ:
                                if ( n == 4'd13 || n == 4'd14 )
                                        p = `DEC_PHY_IRQ_BASE + phy_idx_t'(n - 4'd13);
                        `DEC_MODE_SVC:
                                if ( n == 4'd13 || n == 4'd14 )
                                        p = `DEC_PHY_SVC_BASE + phy_idx_t'(n - 4'd13);
                        `DEC_MODE_ABT:
                                if ( n == 4'd13 || n == 4'd14 )
                                        p = `DEC_PHY_ABT_BASE + phy_idx_t'(n - 4'd13);
                        `DEC_MODE_UND:
                                if ( n == 4'd13 || n == 4'd14 )
                                        p = `DEC_PHY_UND_BASE + phy_idx_t'(n - 4'd13);
                        default:
                                // USR, SYS and unknown modes stay unbanked.
                                p = phy_idx_t'(n);
                        endcase
                        return p;
                end
        endfunction

        // Constants pass untouched, register views get remapped.
        function automatic operand_u map_operand ( input operand_u op, input mode_t mode );
                operand_u       res;
                begin
                        res = op;
                        if ( !op.regs.is_imm )
                                res.regs.idx = map_idx(op.regs.idx, mode);
                        return res;
                end
        endfunction

        // ------------------------------------------------------------------

        always_comb
        begin
                o_uop           = i_uop;
                // Destination is always a register.
                o_uop.dest      = map_idx(i_uop.dest, i_cpsr_mode);
                o_uop.alu_src   = map_operand(i_uop.alu_src, i_cpsr_mode);
                o_uop.shift_src = map_operand(i_uop.shift_src, i_cpsr_mode);
                o_uop.shift_len = map_operand(i_uop.shift_len, i_cpsr_mode);
        end

endmodule

//--- logic/decode_fields.sv
/* Instruction field decoder.
   Splits an ARM word into an architectural micro-op, flags SWI and undefined. */

`timescale 1ns/1ps

`include "decode_macros.svh"

module decode_fields (
        input   logic [31:0]            i_instruction,
        input   logic                   i_instruction_valid,
        output  decode_pkg::uop_t       o_uop,
        output  logic                   o_swi,
        output  logic                   o_und
);

        import decode_pkg::*;

        // Architectural register fields.
        arch_idx_t      rn;
        arch_idx_t      rd;
        arch_idx_t      rs;
        arch_idx_t      rm;

        assign rn = i_instruction[19:16];
        assign rd = i_instruction[15:12];
        assign rs = i_instruction[11:8];
        assign rm = i_instruction[3:0];

        // ------------------------------------------------------------------
        // Class decode and field extraction.
        // ------------------------------------------------------------------

        always_comb
        begin
                // Defaults. Register operands point at r0.
                o_uop           = '0;
                o_uop.cond      = i_instruction[31:28];
                o_swi           = 1'b0;
                o_und           = 1'b0;

                if ( &i_instruction[27:24] )
                begin
                        // Software interrupt. Execute checks the condition.
                        o_swi = 1'b1;
                end
                else if ( i_instruction[27:26] == 2'b00 )
                begin
                        // Data processing.
                        o_uop.alu_op            = alu_op_t'(i_instruction[24:21]);
                        o_uop.flag_update       = i_instruction[20];
                        o_uop.dest              = phy_idx_t'(rd);
                        o_uop.alu_src.regs.idx  = phy_idx_t'(rn);

                        if ( i_instruction[25] )
                        begin
                                // 8-bit constant rotated right by 2 * rot.
                                o_uop.shift_src.imm.is_imm      = 1'b1;
                                o_uop.shift_src.imm.value       =
                                        `DEC_WORD_W'(i_instruction[7:0]);
                                o_uop.shift_op                  = SH_ROR;
                                o_uop.shift_len.imm.is_imm      = 1'b1;
                                o_uop.shift_len.imm.value       =
                                        `DEC_WORD_W'({i_instruction[11:8], 1'b0});
                        end
                        else
                        begin
                                // Rm through the shifter.
                                o_uop.shift_src.regs.idx        = phy_idx_t'(rm);
                                o_uop.shift_op  = shift_op_t'(i_instruction[6:5]);

                                if ( i_instruction[4] && i_instruction[7] )
                                begin
                                        // Multiply/extension space, not handled.
                                        o_und = 1'b1;
                                end
                                else if ( i_instruction[4] )
                                begin
                                        // Shift amount from Rs.
                                        o_uop.shift_len.regs.idx = phy_idx_t'(rs);
                                end
                                else
                                begin
                                        // 5-bit immediate shift amount.
                                        o_uop.shift_len.imm.is_imm      = 1'b1;
                                        o_uop.shift_len.imm.value       =
                                                `DEC_WORD_W'(i_instruction[11:7]);
                                end
                        end
                end
                else
                begin
                        // Loads, stores, branches and the rest.
                        o_und = 1'b1;
                end

                // No instruction. Turn into a bubble.
                if ( !i_instruction_valid )
                begin
                        o_uop.cond      = `DEC_COND_NV;
                        o_swi           = 1'b0;
                        o_und           = 1'b0;
                end
        end

endmodule

//--- logic/decode_pkg.sv
/* Decode stage types.
   Condition, opcode, shift, register index, operand and micro-op formats. */

`include "decode_macros.svh"

package decode_pkg;

        // Basic fields.
        typedef logic [3:0]                     cond_t;
        typedef logic [4:0]                     mode_t;
        typedef logic [`DEC_ARCH_IDX_W-1:0]     arch_idx_t;
        typedef logic [`DEC_PHY_IDX_W-1:0]      phy_idx_t;

        // ARM data-processing opcodes, in encoding order.
        typedef enum logic [3:0] {
                OP_AND, OP_EOR, OP_SUB, OP_RSB,
                OP_ADD, OP_ADC, OP_SBC, OP_RSC,
                OP_TST, OP_TEQ, OP_CMP, OP_CMN,
                OP_ORR, OP_MOV, OP_BIC, OP_MVN
        } alu_op_t;

        // Barrel shifter operations.
        typedef enum logic [1:0] {
                SH_LSL, SH_LSR, SH_ASR, SH_ROR
        } shift_op_t;

        // ------------------------------------------------------------------
        // Operand word. Bit 32 set means constant, clear means register.
        // ------------------------------------------------------------------

        typedef struct packed {
                logic                           is_imm;
                logic [`DEC_WORD_W-1:0]         value;
        } operand_imm_t;

        typedef struct packed {
                logic                                           is_imm;
                logic [`DEC_WORD_W-`DEC_PHY_IDX_W-1:0]          pad;
                phy_idx_t                                       idx;
        } operand_reg_t;

        // Same 33 bits, read as a constant or as an index.
        typedef union packed {
                operand_imm_t   imm;
                operand_reg_t   regs;
        } operand_u;

        // Decoded micro-op handed to execute.
        typedef struct packed {
                cond_t          cond;
                alu_op_t        alu_op;
                logic           flag_update;
                phy_idx_t       dest;
                operand_u       alu_src;
                operand_u       shift_src;
                operand_u       shift_len;
                shift_op_t      shift_op;
        } uop_t;

endpackage

//--- logic/decode_macros.svh
/* Decode stage constants.
   Widths, the NV condition, CPSR mode encodings and physical bank bases. */

`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// Register index and data widths.
`define DEC_ARCH_IDX_W          4
`define DEC_PHY_IDX_W           5
`define DEC_WORD_W              32

// Never condition. Used as the pipeline bubble marker.
`define DEC_COND_NV             4'b1111

// CPSR mode field encodings.
`define DEC_MODE_USR            5'b10000
`define DEC_MODE_FIQ            5'b10001
`define DEC_MODE_IRQ            5'b10010
`define DEC_MODE_SVC            5'b10011
`define DEC_MODE_ABT            5'b10111
`define DEC_MODE_UND            5'b11011
`define DEC_MODE_SYS            5'b11111

// First physical index of each banked register group.
// FIQ banks r8-r14, the others bank r13-r14.
`define DEC_PHY_FIQ_BASE        5'd16
`define DEC_PHY_IRQ_BASE        5'd23
`define DEC_PHY_SVC_BASE        5'd25
`define DEC_PHY_ABT_BASE        5'd27
`define DEC_PHY_UND_BASE        5'd29

`endif
